/* source/epg_pkg.sv */
// ********************
// Shared APB types, slot map and register offsets of the peripheral group
// Slot number sits in address bits 11:8, register offset in bits 7:0
// ********************

package epg_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] slot_t;
	typedef logic [7:0] offset_t;

	// Bit 0 dc select, 1 panel reset, 2 battery supply, 3 logic supply
	typedef logic [3:0] oled_pins_t;

	// Bit 0 reset-not, 1 write protect, 2 hibernate
	typedef logic [2:0] wifi_ctrl_t;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		addr_t addr;
		data_t wdata;
	} apb_req_t;

	typedef struct packed {
		data_t rdata;
		logic ready;
		logic slverr;
	} apb_rsp_t;

	// ********************
	// Slot map
	// ********************
	localparam int SLOT_LSB = 8;
	localparam slot_t SLOT_SYS = 4'd0;
	localparam slot_t SLOT_PINS = 4'd1;

	// System slot
	localparam offset_t REG_TICK_CFG = 8'h00;

	// Board-pin slot
	localparam offset_t REG_OLED_OE = 8'h00;
	localparam offset_t REG_OLED_OVAL = 8'h04;
	localparam offset_t REG_OLED_IVAL = 8'h08;
	localparam offset_t REG_WIFI_CTRL = 8'h0C;
	localparam offset_t REG_WIFI_MASK = 8'h10;
	localparam offset_t REG_WIFI_STAT = 8'h14;

endpackage

/* source/epg_tick_divider.sv */
// ********************
// Pulse coincides with every Nth strobe, divisor 0 acts as 1
// ********************

`timescale 1ns/1ps

module epg_tick_divider #(
	parameter int BW_TICK_DIV = 15
) (
	input logic clk,
	input logic rstnn,
	input logic i_enable,
	input logic [BW_TICK_DIV-1:0] i_divisor,
	input logic i_restart,
	input logic i_tick_1us,
	output logic o_tick_gpio
);

	logic [BW_TICK_DIV-1:0] div_eff;
	logic [BW_TICK_DIV-1:0] count;
	logic count_last;

	assign div_eff = (i_divisor == '0) ? BW_TICK_DIV'(1) : i_divisor;
	assign count_last = (count == div_eff - BW_TICK_DIV'(1));

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			count <= '0;
		else if (i_restart || !i_enable)
			count <= '0;
		else if (i_tick_1us)
		begin
			if (count_last)
				count <= '0;
			else
				count <= count + BW_TICK_DIV'(1);
		end
	end

	// Strobes seen during a restart cycle are not counted
	assign o_tick_gpio = i_enable & i_tick_1us & count_last & ~i_restart;

endmodule

/* source/epg_wifi_irq.sv */
// ********************
// Line is active low, level triggered; clear wins over a new set
// ********************

`timescale 1ns/1ps

module epg_wifi_irq (
	input logic clk,
	input logic rstnn,
	input logic i_itr_n,
	input logic i_clear,
	input logic i_mask,
	output logic o_pending,
	output logic o_interrupt
);

	logic [1:0] itr_sync;
	logic pending;
	logic irq_q;

	// Reset to the idle level so no pending is raised out of reset
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			itr_sync <= 2'b11;
		else
			itr_sync <= {itr_sync[0], i_itr_n};
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			pending <= 1'b0;
		else if (i_clear)
			pending <= 1'b0;
		else if (!itr_sync[1])
			pending <= 1'b1;
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			irq_q <= 1'b0;
		else
			irq_q <= pending & ~i_mask;
	end

	assign o_pending = pending;
	assign o_interrupt = irq_q;

endmodule

/* source/epg_apb_decoder.sv */
// ********************
// Slot decode is combinational, no wait states
// Slots other than 0 and 1 answer with slverr and zero data
// ********************

`timescale 1ns/1ps

module epg_apb_decoder (
	input epg_pkg::apb_req_t i_req,
	input epg_pkg::apb_rsp_t i_sys_rsp,
	input epg_pkg::apb_rsp_t i_pins_rsp,
	output epg_pkg::apb_rsp_t o_rsp,
	output epg_pkg::apb_req_t o_sys_req,
	output epg_pkg::apb_req_t o_pins_req
);
	import epg_pkg::*;

	slot_t slot;
	logic hit_sys;
	logic hit_pins;

	assign slot = i_req.addr[SLOT_LSB +: 4];
	assign hit_sys = (slot == SLOT_SYS);
	assign hit_pins = (slot == SLOT_PINS);

	// Request fan-out, only sel is steered
	always_comb
	begin
		o_sys_req = i_req;
		o_sys_req.sel = i_req.sel & hit_sys;
		o_pins_req = i_req;
		o_pins_req.sel = i_req.sel & hit_pins;
	end

	// ********************
	// Response merge
	// ********************
	always_comb
	begin
		o_rsp.ready = 1'b1;
		if (hit_sys)
		begin
			o_rsp.rdata = i_sys_rsp.rdata;
			o_rsp.slverr = i_sys_rsp.slverr;
		end
		else if (hit_pins)
		begin
			o_rsp.rdata = i_pins_rsp.rdata;
			o_rsp.slverr = i_pins_rsp.slverr;
		end
		else
		begin
			o_rsp.rdata = '0;
			// Error only flagged in the access phase
			o_rsp.slverr = i_req.sel & i_req.enable;
		end
	end

endmodule

/* source/epg_sys_regs.sv */
// ********************
// Tick configuration: bit 0 enable, bits BW_TICK_DIV:1 divisor
// ********************

`timescale 1ns/1ps

module epg_sys_regs #(
	parameter int BW_TICK_DIV = 15
) (
	input logic clk,
	input logic rstnn,
	input epg_pkg::apb_req_t i_req,
	input logic i_tick_1us,
	output epg_pkg::apb_rsp_t o_rsp,
	output logic o_tick_gpio
);
	import epg_pkg::*;

	offset_t offset;
	logic cfg_hit;
	logic cfg_wr;
	logic [BW_TICK_DIV:0] tick_cfg;

	assign offset = i_req.addr[SLOT_LSB-1:0];
	assign cfg_hit = (offset == REG_TICK_CFG);
	assign cfg_wr = i_req.sel & i_req.enable & i_req.write & cfg_hit;

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			tick_cfg <= '0;
		else if (cfg_wr)
			tick_cfg <= i_req.wdata[BW_TICK_DIV:0];
	end

	assign o_rsp.rdata = cfg_hit ? data_t'(tick_cfg) : '0;
	// Ready comes from the decoder
	assign o_rsp.ready = 1'b0;
	assign o_rsp.slverr = 1'b0;

	// The write strobe doubles as the restart pulse
	epg_tick_divider #(
		.BW_TICK_DIV(BW_TICK_DIV)
	) i_tick_divider (
		.clk(clk),
		.rstnn(rstnn),
		.i_enable(tick_cfg[0]),
		.i_divisor(tick_cfg[BW_TICK_DIV:1]),
		.i_restart(cfg_wr),
		.i_tick_1us(i_tick_1us),
		.o_tick_gpio(o_tick_gpio)
	);

endmodule

/* source/epg_board_pins.sv */
// ********************
// OLED pin inputs pass a 2-flop synchronizer, stable 3 cycles before read
// ********************

`timescale 1ns/1ps

module epg_board_pins (
	input logic clk,
	input logic rstnn,
	input epg_pkg::apb_req_t i_req,
	input epg_pkg::oled_pins_t i_oled_ival,
	input logic i_wifi_itr,
	output epg_pkg::apb_rsp_t o_rsp,
	output epg_pkg::oled_pins_t o_oled_oe,
	output epg_pkg::oled_pins_t o_oled_oval,
	output epg_pkg::wifi_ctrl_t o_wifi_ctrl,
	output logic o_wifi_interrupt
);
	import epg_pkg::*;

	offset_t offset;
	logic wr;
	logic stat_clear;

	oled_pins_t oled_oe;
	oled_pins_t oled_oval;
	oled_pins_t ival_meta;
	oled_pins_t ival_sync;
	wifi_ctrl_t wifi_ctrl;
	logic wifi_mask;
	logic wifi_pending;

	assign offset = i_req.addr[SLOT_LSB-1:0];
	assign wr = i_req.sel & i_req.enable & i_req.write;

	// ********************
	// Control registers
	// ********************
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			oled_oe <= '0;
			oled_oval <= '0;
			wifi_ctrl <= '0;
			wifi_mask <= 1'b0;
		end
		else if (wr)
		begin
			case (offset)
				REG_OLED_OE: oled_oe <= i_req.wdata[3:0];
				REG_OLED_OVAL: oled_oval <= i_req.wdata[3:0];
				REG_WIFI_CTRL: wifi_ctrl <= i_req.wdata[2:0];
				REG_WIFI_MASK: wifi_mask <= i_req.wdata[0];
				default: ;
			endcase
		end
	end

	// Pin readback synchronizer
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			ival_meta <= '0;
			ival_sync <= '0;
		end
		else
		begin
			ival_meta <= i_oled_ival;
			ival_sync <= ival_meta;
		end
	end

	// Write 1 to clear
	assign stat_clear = wr & (offset == REG_WIFI_STAT) & i_req.wdata[0];

	epg_wifi_irq i_wifi_irq (
		.clk(clk),
		.rstnn(rstnn),
		.i_itr_n(i_wifi_itr),
		.i_clear(stat_clear),
		.i_mask(wifi_mask),
		.o_pending(wifi_pending),
		.o_interrupt(o_wifi_interrupt)
	);

	// ********************
	// Read mux
	// ********************
	always_comb
	begin
		o_rsp.rdata = '0;
		case (offset)
			REG_OLED_OE: o_rsp.rdata = data_t'(oled_oe);
			REG_OLED_OVAL: o_rsp.rdata = data_t'(oled_oval);
			REG_OLED_IVAL: o_rsp.rdata = data_t'(ival_sync);
			REG_WIFI_CTRL: o_rsp.rdata = data_t'(wifi_ctrl);
			REG_WIFI_MASK: o_rsp.rdata = data_t'(wifi_mask);
			REG_WIFI_STAT: o_rsp.rdata = data_t'(wifi_pending);
			default: o_rsp.rdata = '0;
		endcase
	end

	// Ready comes from the decoder
	assign o_rsp.ready = 1'b0;
	assign o_rsp.slverr = 1'b0;

	assign o_oled_oe = oled_oe;
	assign o_oled_oval = oled_oval;
	assign o_wifi_ctrl = wifi_ctrl;

endmodule

/* source/epg_top.sv */
// ********************
// APB target, zero wait states; slot 0 system, slot 1 board pins
// ********************

`timescale 1ns/1ps

module epg_top #(
	parameter int BW_TICK_DIV = 15
) (
	input logic clk,
	input logic rstnn,
	input logic i_psel,
	input logic i_penable,
	input logic i_pwrite,
	input epg_pkg::addr_t i_paddr,
	input epg_pkg::data_t i_pwdata,
	output epg_pkg::data_t o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	input logic i_tick_1us,
	output logic o_tick_gpio,
	input epg_pkg::oled_pins_t i_oled_ival,
	output epg_pkg::oled_pins_t o_oled_oe,
	output epg_pkg::oled_pins_t o_oled_oval,
	input logic i_wifi_itr,
	output epg_pkg::wifi_ctrl_t o_wifi_ctrl,
	output logic o_wifi_interrupt
);
	import epg_pkg::*;

	apb_req_t req;
	apb_rsp_t rsp;
	apb_req_t sys_req;
	apb_rsp_t sys_rsp;
	apb_req_t pins_req;
	apb_rsp_t pins_rsp;

	assign req.sel = i_psel;
	assign req.enable = i_penable;
	assign req.write = i_pwrite;
	assign req.addr = i_paddr;
	assign req.wdata = i_pwdata;

	assign o_prdata = rsp.rdata;
	assign o_pready = rsp.ready;
	assign o_pslverr = rsp.slverr;

	epg_apb_decoder i_apb_decoder (
		.i_req(req),
		.i_sys_rsp(sys_rsp),
		.i_pins_rsp(pins_rsp),
		.o_rsp(rsp),
		.o_sys_req(sys_req),
		.o_pins_req(pins_req)
	);

	epg_sys_regs #(
		.BW_TICK_DIV(BW_TICK_DIV)
	) i_sys_regs (
		.clk(clk),
		.rstnn(rstnn),
		.i_req(sys_req),
		.i_tick_1us(i_tick_1us),
		.o_rsp(sys_rsp),
		.o_tick_gpio(o_tick_gpio)
	);

	epg_board_pins i_board_pins (
		.clk(clk),
		.rstnn(rstnn),
		.i_req(pins_req),
		.i_oled_ival(i_oled_ival),
		.i_wifi_itr(i_wifi_itr),
		.o_rsp(pins_rsp),
		.o_oled_oe(o_oled_oe),
		.o_oled_oval(o_oled_oval),
		.o_wifi_ctrl(o_wifi_ctrl),
		.o_wifi_interrupt(o_wifi_interrupt)
	);

endmodule

/* test/epg_checker.sv */
// ********************
// Reference model sampled at each rising edge, inputs must settle before it
// ********************

`timescale 1ns/1ps

module epg_checker #(
	parameter int BW_TICK_DIV = 15
) (
	input logic clk,
	input logic rstnn,
	input logic i_psel,
	input logic i_penable,
	input logic i_pwrite,
	input epg_pkg::addr_t i_paddr,
	input epg_pkg::data_t i_pwdata,
	input epg_pkg::data_t i_prdata,
	input logic i_pready,
	input logic i_pslverr,
	input logic i_tick_1us,
	input logic i_tick_gpio,
	input epg_pkg::oled_pins_t i_oled_ival,
	input epg_pkg::oled_pins_t i_oled_oe,
	input epg_pkg::oled_pins_t i_oled_oval,
	input logic i_wifi_itr,
	input epg_pkg::wifi_ctrl_t i_wifi_ctrl,
	input logic i_wifi_interrupt,
	output int o_errors,
	output int o_checks
);
	import epg_pkg::*;

	logic [BW_TICK_DIV:0] m_cfg;
	int m_strobes;
	int tick_n;
	oled_pins_t m_oe;
	oled_pins_t m_oval;
	oled_pins_t m_s1;
	oled_pins_t m_s2;
	wifi_ctrl_t m_ctrl;
	logic m_mask;
	logic m_w1;
	logic m_w2;
	logic m_pend;
	logic m_irq;
	logic acc;
	logic restart;
	logic clear;
	logic exp_tick;
	slot_t slot;
	offset_t off;

	function automatic data_t model_read(slot_t s, offset_t o);
		if (s == SLOT_SYS)
			return (o == REG_TICK_CFG) ? data_t'(m_cfg) : '0;
		if (s != SLOT_PINS)
			return '0;
		case (o)
			REG_OLED_OE: return data_t'(m_oe);
			REG_OLED_OVAL: return data_t'(m_oval);
			REG_OLED_IVAL: return data_t'(m_s2);
			REG_WIFI_CTRL: return data_t'(m_ctrl);
			REG_WIFI_MASK: return data_t'(m_mask);
			REG_WIFI_STAT: return data_t'(m_pend);
			default: return '0;
		endcase
	endfunction

	task automatic check(input logic ok, input string msg);
		o_checks++;
		if (!ok)
		begin
			o_errors++;
			$display("Fail %0t ns: %s", $time, msg);
		end
	endtask

	initial
	begin
		o_errors = 0;
		o_checks = 0;
	end

	always @(posedge clk)
	begin
		if (!rstnn)
		begin
			m_cfg = '0;
			m_strobes = 0;
			m_oe = '0;
			m_oval = '0;
			m_s1 = '0;
			m_s2 = '0;
			m_ctrl = '0;
			m_mask = 1'b0;
			m_w1 = 1'b1;
			m_w2 = 1'b1;
			m_pend = 1'b0;
			m_irq = 1'b0;
		end
		else
		begin
			acc = i_psel & i_penable;
			slot = i_paddr[11:8];
			off = i_paddr[7:0];
			restart = acc & i_pwrite & (slot == SLOT_SYS) & (off == REG_TICK_CFG);
			clear = acc & i_pwrite & (slot == SLOT_PINS) & (off == REG_WIFI_STAT) & i_pwdata[0];
			// Pulse on every Nth strobe since the last configuration write
			tick_n = (m_cfg[BW_TICK_DIV:1] == '0) ? 1 : int'(m_cfg[BW_TICK_DIV:1]);
			exp_tick = m_cfg[0] & i_tick_1us & ~restart & ((m_strobes + 1) % tick_n == 0);

			// ********************
			// Compare
			// ********************
			if (acc)
			begin
				check(i_pready, "pready low in access cycle");
				check(i_pslverr == (slot > SLOT_PINS),
					$sformatf("slot %0d slverr %b", slot, i_pslverr));
				if (!i_pwrite)
					check(i_prdata == model_read(slot, off),
						$sformatf("read slot %0d off %h got %h exp %h",
						slot, off, i_prdata, model_read(slot, off)));
			end
			check(i_tick_gpio == exp_tick,
				$sformatf("tick %b exp %b", i_tick_gpio, exp_tick));
			check(i_oled_oe == m_oe, $sformatf("oled_oe %h exp %h", i_oled_oe, m_oe));
			check(i_oled_oval == m_oval,
				$sformatf("oled_oval %h exp %h", i_oled_oval, m_oval));
			check(i_wifi_ctrl == m_ctrl,
				$sformatf("wifi_ctrl %h exp %h", i_wifi_ctrl, m_ctrl));
			check(i_wifi_interrupt == m_irq,
				$sformatf("wifi_interrupt %b exp %b", i_wifi_interrupt, m_irq));

			// ********************
			// Model update
			// ********************
			if (restart || !m_cfg[0])
				m_strobes = 0;
			else if (i_tick_1us)
				m_strobes++;
			m_irq = m_pend & ~m_mask;
			if (clear)
				m_pend = 1'b0;
			else if (!m_w2)
				m_pend = 1'b1;
			m_w2 = m_w1;
			m_w1 = i_wifi_itr;
			m_s2 = m_s1;
			m_s1 = i_oled_ival;
			if (restart)
				m_cfg = i_pwdata[BW_TICK_DIV:0];
			if (acc && i_pwrite && slot == SLOT_PINS)
			begin
				case (off)
					REG_OLED_OE: m_oe = i_pwdata[3:0];
					REG_OLED_OVAL: m_oval = i_pwdata[3:0];
					REG_WIFI_CTRL: m_ctrl = i_pwdata[2:0];
					REG_WIFI_MASK: m_mask = i_pwdata[0];
					default: ;
				endcase
			end
		end
	end

endmodule

/* test/epg_tb.sv */
// ********************
// Random APB traffic, pin and strobe stimulus; checker compares every cycle
// ********************

`timescale 1ns/1ps

module epg_tb;
	import epg_pkg::*;

	localparam int BW_TICK_DIV = 15;
	// Rough cycle budget per test, summed for the watchdog
	localparam int WATCHDOG_CYCLES = 20 + 400 + 400 + 200 + 700 + 150 + 500;

	logic clk;
	logic rstnn;
	logic psel;
	logic penable;
	logic pwrite;
	addr_t paddr;
	data_t pwdata;
	data_t prdata;
	logic pready;
	logic pslverr;
	logic tick_1us;
	logic tick_gpio;
	logic strobes_on;
	oled_pins_t oled_ival;
	oled_pins_t oled_oe;
	oled_pins_t oled_oval;
	logic wifi_itr;
	wifi_ctrl_t wifi_ctrl;
	logic wifi_interrupt;
	int errors;
	int checks;
	int err_before;

	epg_top #(.BW_TICK_DIV(BW_TICK_DIV)) i_epg_top (
		.clk(clk), .rstnn(rstnn),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.i_tick_1us(tick_1us), .o_tick_gpio(tick_gpio),
		.i_oled_ival(oled_ival), .o_oled_oe(oled_oe), .o_oled_oval(oled_oval),
		.i_wifi_itr(wifi_itr), .o_wifi_ctrl(wifi_ctrl), .o_wifi_interrupt(wifi_interrupt)
	);

	epg_checker #(.BW_TICK_DIV(BW_TICK_DIV)) i_checker (
		.clk(clk), .rstnn(rstnn),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.i_prdata(prdata), .i_pready(pready), .i_pslverr(pslverr),
		.i_tick_1us(tick_1us), .i_tick_gpio(tick_gpio),
		.i_oled_ival(oled_ival), .i_oled_oe(oled_oe), .i_oled_oval(oled_oval),
		.i_wifi_itr(wifi_itr), .i_wifi_ctrl(wifi_ctrl), .i_wifi_interrupt(wifi_interrupt),
		.o_errors(errors), .o_checks(checks)
	);

	always #5 clk = ~clk;

	// Random 1 us strobes, roughly one cycle in three
	always @(posedge clk)
	begin
		#1 tick_1us = strobes_on & ($urandom_range(2, 0) == 0);
	end

	task automatic apb_access(input logic wr, input slot_t s, input offset_t o, input data_t d);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = {20'h0, s, o};
		pwdata = d;
		@(posedge clk);
		#1 penable = 1'b1;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic read_all_regs;
		apb_access(1'b0, SLOT_SYS, REG_TICK_CFG, '0);
		for (int i = 0; i < 6; i++)
			apb_access(1'b0, SLOT_PINS, offset_t'(4 * i), '0);
	endtask

	// Mostly known offsets, sometimes an unknown one
	function automatic offset_t random_offset;
		if ($urandom_range(3, 0) == 0)
			return offset_t'(4 * $urandom_range(63, 6));
		return offset_t'(4 * $urandom_range(5, 0));
	endfunction

	task automatic report_test(input string name);
		$display("Test %s: %0d errors", name, errors - err_before);
		err_before = errors;
	endtask

	initial
	begin
		void'($urandom(32'hb1ef));
		clk = 1'b0;
		rstnn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		tick_1us = 1'b0;
		strobes_on = 1'b0;
		oled_ival = '0;
		wifi_itr = 1'b1;
		err_before = 0;
		repeat (10) @(posedge clk);
		#1 rstnn = 1'b1;
		wait_cycles(2);

		// Every offset written once, then mixed traffic
		apb_access(1'b1, SLOT_SYS, REG_TICK_CFG, $urandom());
		for (int i = 0; i < 6; i++)
			apb_access(1'b1, SLOT_PINS, offset_t'(4 * i), $urandom());
		for (int i = 0; i < 40; i++)
			apb_access(1'($urandom_range(1, 0)), slot_t'($urandom_range(1, 0)),
				random_offset(), $urandom());
		read_all_regs();
		report_test("register readback");

		for (int i = 0; i < 40; i++)
			apb_access(1'($urandom_range(1, 0)), slot_t'($urandom_range(15, 2)),
				random_offset(), $urandom());
		read_all_regs();
		report_test("unmapped slots");

		for (int i = 0; i < 15; i++)
		begin
			oled_ival = oled_pins_t'($urandom());
			apb_access(1'b1, SLOT_PINS, offset_t'(4 * $urandom_range(1, 0)), $urandom());
			apb_access(1'b1, SLOT_PINS, REG_WIFI_CTRL, $urandom());
			apb_access(1'b0, SLOT_PINS, REG_OLED_IVAL, '0);
		end
		report_test("board pins");

		strobes_on = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			apb_access(1'b1, SLOT_SYS, REG_TICK_CFG,
				{27'h0, (i == 0) ? 4'h0 : 4'($urandom_range(6, 0)), 1'b1});
			wait_cycles(60);
		end
		apb_access(1'b1, SLOT_SYS, REG_TICK_CFG, 32'h4);
		wait_cycles(50);
		strobes_on = 1'b0;
		report_test("tick divider");

		for (int m = 0; m < 2; m++)
		begin
			apb_access(1'b1, SLOT_PINS, REG_WIFI_MASK, data_t'(m));
			wifi_itr = 1'b0;
			wait_cycles(4);
			apb_access(1'b0, SLOT_PINS, REG_WIFI_STAT, '0);
			apb_access(1'b1, SLOT_PINS, REG_WIFI_STAT, 32'h1);
			apb_access(1'b0, SLOT_PINS, REG_WIFI_STAT, '0);
			wifi_itr = 1'b1;
			wait_cycles(4);
			apb_access(1'b1, SLOT_PINS, REG_WIFI_STAT, 32'h1);
			apb_access(1'b0, SLOT_PINS, REG_WIFI_STAT, '0);
			wait_cycles(3);
		end
		report_test("wifi interrupt");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog timed out before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* epg_lite.f */
source/epg_pkg.sv
source/epg_tick_divider.sv
source/epg_wifi_irq.sv
source/epg_apb_decoder.sv
source/epg_sys_regs.sv
source/epg_board_pins.sv
source/epg_top.sv
test/epg_checker.sv
test/epg_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the peripheral group simulation with Verilator
# Exit status is 0 only when the log holds no failure report

rm -rf obj_dir sim.log build.log

verilator --binary --timing -f epg_lite.f --top-module epg_tb -Mdir obj_dir -o epg_sim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/epg_sim > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
